// File: tb.f
ecc_mem_pkg.sv
ecc_cmd_pkg.sv
ecc_adder.sv
ecc_fixed_msb.sv
mem_arbiter.sv
scalar_store.sv
msb_fix_engine.sv
ecc_scalar_blind_top.sv
tb_ecc_scalar_blind.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_ecc_scalar_blind \
    -o tb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { echo "simulation exited with an error"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || {
    echo "simulation failed, see sim.log"
    exit 1
}

// File: tb_ecc_scalar_blind.sv
/* testbench for the scalar blinding subsystem
   directed tests over the host bus, command and completion streams */

`default_nettype none

module tb_ecc_scalar_blind;

    timeunit 1ns;
    timeprecision 100ps;

    import ecc_mem_pkg::*;
    import ecc_cmd_pkg::*;

    localparam int          REG_SIZE = 64;
    localparam logic [63:0] Q        = 64'hf3a9_5c17_e2d4_8b61;
    localparam int          NUM_RD   = REG_SIZE / WORD_W;
    localparam int          NUM_WR   = NUM_RD + 1;

    // ==================================================================
    // cycle budget for the watchdog
    // ==================================================================

    // one host beat with its idle cycle and read response
    localparam int BEAT     = 3;
    // reads, two compute cycles, writes and handshakes
    localparam int OP       = NUM_RD + 2 + NUM_WR + 3;
    localparam int FIX_TEST = NUM_RD * BEAT + 2 + OP + 2 + NUM_WR * BEAT;
    // reset, round trip, 24 engine runs, contention reads, done hold
    localparam int TOTAL    = 4 + 2 * SLOT_WORDS * BEAT + 24 * FIX_TEST + 6 * BEAT + 8;
    localparam int LIMIT    = 8 * TOTAL;

    logic      clk;
    logic      reset_n;
    mem_req_t  host_req;
    logic      host_req_valid;
    logic      host_req_ready;
    mem_rsp_t  host_rsp;
    logic      host_rsp_valid;
    fix_cmd_t  cmd;
    logic      cmd_valid;
    logic      cmd_ready;
    fix_done_t done;
    logic      done_valid;
    logic      done_ready;

    int          value_errors;
    int          other_errors;
    int          cycle_cnt;
    integer      seed;

    ecc_scalar_blind_top #(
        .REG_SIZE    (REG_SIZE),
        .GROUP_ORDER (Q)
    ) UUT (
        .clk            (clk),
        .reset_n        (reset_n),
        .host_req       (host_req),
        .host_req_valid (host_req_valid),
        .host_req_ready (host_req_ready),
        .host_rsp       (host_rsp),
        .host_rsp_valid (host_rsp_valid),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .done           (done),
        .done_valid     (done_valid),
        .done_ready     (done_ready)
    );

    // 40 ns period
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // watchdog, ends a hung run
    initial begin
        while (cycle_cnt < LIMIT) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles", LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // fill pattern, every address bit matters
    function automatic logic [WORD_W-1:0] fill_word(mem_addr_t a);
        return {a, 26'h0} ^ (32'h9e37_79b9 * (32'(a) + 32'd1));
    endfunction

    // ==================================================================
    // compare tasks
    // ==================================================================

    task automatic compare_word(string name, mem_rsp_t exp, mem_rsp_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp.rdata, act.rdata);
            value_errors++;
        end
    endtask

    task automatic compare_done(string name, fix_done_t exp, fix_done_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected dst=%0d wide=%0b got dst=%0d wide=%0b",
                     $time, name, exp.dst, exp.wide, act.dst, act.wide);
            value_errors++;
        end
    endtask

    // ==================================================================
    // bus and command tasks
    // ==================================================================

    // one beat on the host bus, transfer lands on the returned posedge
    task automatic bus_transfer(logic wr, mem_addr_t a, logic [WORD_W-1:0] d);
        mem_req_t r;
        r.write = wr;
        r.addr  = a;
        r.wdata = d;
        @(posedge clk);
        host_req       <= r;
        host_req_valid <= 1'b1;
        @(negedge clk);
        while (!host_req_ready) @(negedge clk);
        @(posedge clk);
        host_req_valid <= 1'b0;
    endtask

    task automatic host_write_scalar(slot_t s, logic [REG_SIZE-1:0] k);
        for (int w = 0; w < NUM_RD; w++) begin
            bus_transfer(1'b1, {s, 4'(w)}, k[w*WORD_W +: WORD_W]);
        end
    endtask

    task automatic host_read_word(mem_addr_t a, output mem_rsp_t d);
        bus_transfer(1'b0, a, '0);
        @(negedge clk);
        if (!host_rsp_valid) begin
            $display("ERROR: no read response for host address %0d at %0t", a, $time);
            other_errors++;
        end
        d = host_rsp;
    endtask

    task automatic start_fix(slot_t src, slot_t dst);
        @(posedge clk);
        cmd.src   <= src;
        cmd.dst   <= dst;
        cmd_valid <= 1'b1;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    // waits for completion, captures it and acknowledges it
    task automatic wait_done(output fix_done_t d);
        @(negedge clk);
        while (!done_valid) @(negedge clk);
        d = done;
        @(posedge clk);
        done_ready <= 1'b1;
        @(posedge clk);
        done_ready <= 1'b0;
    endtask

    // expected result from the selection rule
    task automatic check_result(slot_t dst, logic [REG_SIZE-1:0] k, fix_done_t d);
        logic [REG_SIZE+1:0] sum_q;
        logic [REG_SIZE+1:0] sum_2q;
        logic [REG_SIZE:0]   exp_val;
        fix_done_t           exp_done;
        mem_rsp_t            got;
        mem_rsp_t            want;
        sum_q  = {2'b00, k} + {2'b00, Q};
        sum_2q = sum_q + {2'b00, Q};
        // scalar+q kept only when it carries out of REG_SIZE bits
        exp_val       = sum_q[REG_SIZE] ? sum_q[REG_SIZE:0] : sum_2q[REG_SIZE:0];
        exp_done.dst  = dst;
        exp_done.wide = sum_q[REG_SIZE];
        compare_done("done", exp_done, d);
        for (int w = 0; w < NUM_RD; w++) begin
            host_read_word({dst, 4'(w)}, got);
            want.rdata = exp_val[w*WORD_W +: WORD_W];
            compare_word($sformatf("result word %0d", w), want, got);
        end
        // top word carries only the fixed MSB
        host_read_word({dst, 4'(NUM_RD)}, got);
        want.rdata = 32'd1;
        compare_word("result top word", want, got);
    endtask

    task automatic run_fix(slot_t src, slot_t dst, logic [REG_SIZE-1:0] k);
        fix_done_t d;
        host_write_scalar(src, k);
        start_fix(src, dst);
        wait_done(d);
        check_result(dst, k, d);
    endtask

    // ==================================================================
    // directed tests
    // ==================================================================

    task automatic test_round_trip();
        mem_rsp_t got;
        mem_rsp_t want;
        for (int w = 0; w < SLOT_WORDS; w++) begin
            bus_transfer(1'b1, {2'd2, 4'(w)}, fill_word({2'd2, 4'(w)}));
        end
        for (int w = 0; w < SLOT_WORDS; w++) begin
            host_read_word({2'd2, 4'(w)}, got);
            want.rdata = fill_word({2'd2, 4'(w)});
            compare_word($sformatf("slot 2 word %0d", w), want, got);
        end
    endtask

    task automatic test_random();
        logic [REG_SIZE-1:0] k;
        for (int i = 0; i < 20; i++) begin
            k = {32'($random(seed)), 32'($random(seed))};
            run_fix(2'd0, 2'd1, k % Q);
        end
    endtask

    // host hammers slot 2 while the engine works from slot 0 into slot 3
    task automatic test_contention();
        logic [REG_SIZE-1:0] k;
        fix_done_t           d;
        mem_rsp_t            got;
        mem_rsp_t            want;
        k = 64'h7b1d_04e9_3c5a_f012;
        host_write_scalar(2'd0, k);
        start_fix(2'd0, 2'd3);
        for (int i = 0; i < 6; i++) begin
            host_read_word({2'd2, 4'(i)}, got);
            want.rdata = fill_word({2'd2, 4'(i)});
            compare_word($sformatf("contended slot 2 word %0d", i), want, got);
        end
        wait_done(d);
        check_result(2'd3, k, d);
    endtask

    task automatic test_done_hold();
        logic [REG_SIZE-1:0] k;
        logic [REG_SIZE:0]   sum_q;
        fix_done_t           want;
        fix_done_t           d;
        k = Q - 64'd5;
        // completion the selection rule calls for
        sum_q     = {1'b0, k} + {1'b0, Q};
        want.dst  = 2'd1;
        want.wide = sum_q[REG_SIZE];
        host_write_scalar(2'd0, k);
        start_fix(2'd0, 2'd1);
        @(negedge clk);
        while (!done_valid) @(negedge clk);
        compare_done("held done", want, done);
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (!done_valid) begin
                $display("ERROR: done_valid dropped without done_ready at %0t", $time);
                other_errors++;
            end
            if (cmd_ready) begin
                $display("ERROR: cmd_ready rose while completion pending at %0t", $time);
                other_errors++;
            end
            compare_done("held done", want, done);
        end
        wait_done(d);
        check_result(2'd1, k, d);
    endtask

    initial begin
        clk            = 1'b0;
        reset_n        = 1'b0;
        host_req       = '0;
        host_req_valid = 1'b0;
        cmd            = '0;
        cmd_valid      = 1'b0;
        done_ready     = 1'b0;
        value_errors   = 0;
        other_errors   = 0;
        cycle_cnt      = 0;
        seed           = 32'hb215;

        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        if (!cmd_ready || done_valid || host_req_ready || host_rsp_valid) begin
            $display("ERROR: handshake outputs wrong after reset");
            other_errors++;
        end

        test_round_trip();
        // small scalar keeps scalar+2q
        run_fix(2'd0, 2'd1, 64'h0000_0000_1234_5678);
        // scalar just below q keeps scalar+q
        run_fix(2'd0, 2'd1, Q - 64'd1);
        test_random();
        test_contention();
        test_done_hold();

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ecc_scalar_blind_top.sv
/* scalar blinding subsystem top, store, arbiter and MSB-fix engine
   joined on one shared memory bus */

`default_nettype none

module ecc_scalar_blind_top #(
    parameter int                  REG_SIZE    = 384,
    parameter logic [REG_SIZE-1:0] GROUP_ORDER = {
        192'hffffffffffffffffffffffffffffffffffffffffffffffff,
        192'hc7634d81f4372ddf581a0db248b0a77aecec196accc52973
    }
) (
    input  wire                     clk,
    input  wire                     reset_n,
    // host port on the shared store bus
    input  wire ecc_mem_pkg::mem_req_t host_req,
    input  wire                     host_req_valid,
    output logic                    host_req_ready,
    output ecc_mem_pkg::mem_rsp_t   host_rsp,
    output logic                    host_rsp_valid,
    // command and completion streams
    input  wire ecc_cmd_pkg::fix_cmd_t cmd,
    input  wire                     cmd_valid,
    output logic                    cmd_ready,
    output ecc_cmd_pkg::fix_done_t  done,
    output logic                    done_valid,
    input  wire                     done_ready
);

    import ecc_mem_pkg::*;

    // ==================================================================
    // internal bus nets
    // ==================================================================

    mem_req_t eng_req;
    logic     eng_valid;
    logic     eng_ready;
    logic     eng_rsp_valid;
    mem_req_t mem_req;
    logic     mem_valid;
    // store read data, seen by both requesters
    mem_rsp_t store_rsp;

    assign host_rsp = store_rsp;

    mem_arbiter u_arbiter (
        .clk            (clk),
        .reset_n        (reset_n),
        .host_req       (host_req),
        .host_valid     (host_req_valid),
        .host_ready     (host_req_ready),
        .host_rsp_valid (host_rsp_valid),
        .eng_req        (eng_req),
        .eng_valid      (eng_valid),
        .eng_ready      (eng_ready),
        .eng_rsp_valid  (eng_rsp_valid),
        .mem_req        (mem_req),
        .mem_valid      (mem_valid)
    );

    scalar_store u_store (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .rsp       (store_rsp)
    );

    msb_fix_engine #(
        .REG_SIZE    (REG_SIZE),
        .GROUP_ORDER (GROUP_ORDER)
    ) u_engine (
        .clk           (clk),
        .reset_n       (reset_n),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .done          (done),
        .done_valid    (done_valid),
        .done_ready    (done_ready),
        .eng_req       (eng_req),
        .eng_valid     (eng_valid),
        .eng_ready     (eng_ready),
        .eng_rsp_valid (eng_rsp_valid),
        .rsp           (store_rsp)
    );

endmodule

`default_nettype wire

// File: msb_fix_engine.sv
/* MSB-fix engine FSM, gathers a scalar from the store, runs the
   fixed-MSB block and writes the REG_SIZE+1-bit result back */

`default_nettype none

module msb_fix_engine #(
    parameter int                  REG_SIZE    = 384,
    parameter logic [REG_SIZE-1:0] GROUP_ORDER = {
        192'hffffffffffffffffffffffffffffffffffffffffffffffff,
        192'hc7634d81f4372ddf581a0db248b0a77aecec196accc52973
    }
) (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire ecc_cmd_pkg::fix_cmd_t cmd,
    input  wire                     cmd_valid,
    output logic                    cmd_ready,
    output ecc_cmd_pkg::fix_done_t  done,
    output logic                    done_valid,
    input  wire                     done_ready,
    output ecc_mem_pkg::mem_req_t   eng_req,
    output logic                    eng_valid,
    input  wire                     eng_ready,
    input  wire                     eng_rsp_valid,
    input  wire ecc_mem_pkg::mem_rsp_t rsp
);

    import ecc_mem_pkg::*;
    import ecc_cmd_pkg::*;

    // words read, words written (extra word carries bit REG_SIZE)
    localparam int NUM_RD = REG_SIZE / WORD_W;
    localparam int NUM_WR = NUM_RD + 1;
    localparam int WIDX_W = $clog2(SLOT_WORDS);
    localparam int CNT_W  = WIDX_W + 1;
    // result padded to whole words
    localparam int PAD_W  = NUM_WR * WORD_W;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_COMPUTE,
        ST_WRITE,
        ST_DONE
    } state_t;

    state_t state;

    // read issue and response counters, write word index
    logic [CNT_W-1:0] rd_issued;
    logic [CNT_W-1:0] rd_recv;
    logic [CNT_W-1:0] wr_idx;
    // second compute cycle
    logic             cmp_cnt;

    slot_t               src_slot;
    slot_t               dst_slot;
    logic [REG_SIZE-1:0] scalar;
    logic [REG_SIZE:0]   fixed;
    logic [PAD_W-1:0]    fixed_pad;
    logic                wide;
    logic                rsp_take;
    logic                last_rsp;
    logic                last_wr;

    // ==================================================================
    // handshakes and decode
    // ==================================================================

    assign cmd_ready  = (state == ST_IDLE);
    assign done_valid = (state == ST_DONE);

    // scalar+q carries out exactly when scalar > 2^REG_SIZE - q - 1
    assign wide = (scalar > ~GROUP_ORDER);

    assign fixed_pad = {{(PAD_W-REG_SIZE-1){1'b0}}, fixed};

    // responses only count while gathering
    assign rsp_take = (state == ST_READ) && eng_rsp_valid;
    assign last_rsp = rsp_take && (rd_recv == CNT_W'(NUM_RD - 1));
    assign last_wr  = (state == ST_WRITE) && eng_ready
                      && (wr_idx == CNT_W'(NUM_WR - 1));

    // bus beat per state
    always_comb begin
        eng_req   = '0;
        eng_valid = 1'b0;
        case (state)
            ST_READ: begin
                // back to back reads, each answered exactly once
                eng_valid    = (rd_issued < CNT_W'(NUM_RD));
                eng_req.addr = {src_slot, rd_issued[WIDX_W-1:0]};
            end
            ST_WRITE: begin
                eng_valid     = 1'b1;
                eng_req.write = 1'b1;
                eng_req.addr  = {dst_slot, wr_idx[WIDX_W-1:0]};
                // low word first, last word holds only the MSB
                eng_req.wdata = fixed_pad[wr_idx*WORD_W +: WORD_W];
            end
            default: begin
            end
        endcase
    end

    // ==================================================================
    // FSM and counters
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= ST_IDLE;
            rd_issued <= '0;
            rd_recv   <= '0;
            wr_idx    <= '0;
            cmp_cnt   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        rd_issued <= '0;
                        rd_recv   <= '0;
                        wr_idx    <= '0;
                        cmp_cnt   <= 1'b0;
                        state     <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (eng_valid && eng_ready) begin
                        rd_issued <= rd_issued + 1'b1;
                    end
                    if (rsp_take) begin
                        rd_recv <= rd_recv + 1'b1;
                    end
                    if (last_rsp) begin
                        state <= ST_COMPUTE;
                    end
                end
                ST_COMPUTE: begin
                    // enable held for exactly two cycles
                    cmp_cnt <= 1'b1;
                    if (cmp_cnt) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (eng_ready) begin
                        wr_idx <= wr_idx + 1'b1;
                    end
                    if (last_wr) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // completion held until the host takes it
                    if (done_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // slots, scalar and completion contents
    always_ff @(posedge clk) begin
        if (cmd_ready && cmd_valid) begin
            src_slot <= cmd.src;
            dst_slot <= cmd.dst;
        end
        // word 0 arrives first and ends up at the bottom
        if (rsp_take) begin
            scalar <= {rsp.rdata, scalar[REG_SIZE-1:WORD_W]};
        end
        if (last_wr) begin
            done.dst  <= dst_slot;
            done.wide <= wide;
        end
    end

    // fixed-MSB block, output stays put once the enable drops
    ecc_fixed_msb #(
        .REG_SIZE    (REG_SIZE),
        .GROUP_ORDER (GROUP_ORDER)
    ) u_fixed_msb (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (state == ST_COMPUTE),
        .data     (scalar),
        .data_out (fixed)
    );

    // every issued read has been answered once the gather phase ends
    a_no_read_left: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(state == ST_READ) |-> (rd_issued == rd_recv));

endmodule

`default_nettype wire

// File: scalar_store.sv
/* single-port word memory holding the scalar slots,
   writes at the transfer edge and reads with one cycle of latency */

`default_nettype none

module scalar_store (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire ecc_mem_pkg::mem_req_t mem_req,
    input  wire                   mem_valid,
    output ecc_mem_pkg::mem_rsp_t rsp
);

    import ecc_mem_pkg::*;

    // one entry per word of every slot
    localparam int DEPTH = NUM_SLOTS * SLOT_WORDS;

    logic [WORD_W-1:0] mem [DEPTH];

    // read and write decode of the current beat
    logic do_write;
    logic do_read;

    assign do_write = mem_valid && mem_req.write;
    assign do_read  = mem_valid && !mem_req.write;

    // word array, contents are undefined until written
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    // read data register
    // holds the last read word until the next read
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rsp <= '0;
        end else if (do_read) begin
            rsp.rdata <= mem[mem_req.addr];
        end
    end

endmodule

`default_nettype wire

// File: mem_arbiter.sv
/* round-robin arbiter between host and engine on the shared store bus,
   with read-response routing back to the issuing requester */

`default_nettype none

module mem_arbiter (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire ecc_mem_pkg::mem_req_t host_req,
    input  wire                   host_valid,
    output logic                  host_ready,
    output logic                  host_rsp_valid,
    input  wire ecc_mem_pkg::mem_req_t eng_req,
    input  wire                   eng_valid,
    output logic                  eng_ready,
    output logic                  eng_rsp_valid,
    output ecc_mem_pkg::mem_req_t mem_req,
    output logic                  mem_valid
);

    import ecc_mem_pkg::*;

    // last winner, set when the engine took the previous grant
    logic last_eng;

    // under contention the requester that did not win last goes first
    always_comb begin
        if (host_valid && eng_valid) begin
            host_ready = last_eng;
            eng_ready  = !last_eng;
        end else begin
            host_ready = host_valid;
            eng_ready  = eng_valid;
        end
    end

    // forward the granted beat to the store
    assign mem_valid = host_ready | eng_ready;
    assign mem_req   = eng_ready ? eng_req : host_req;

    // remember the winner and who is owed a read response
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            last_eng       <= 1'b0;
            host_rsp_valid <= 1'b0;
            eng_rsp_valid  <= 1'b0;
        end else begin
            if (mem_valid) begin
                last_eng <= eng_ready;
            end
            // store answers one cycle after the read transfer
            host_rsp_valid <= host_ready && !host_req.write;
            eng_rsp_valid  <= eng_ready && !eng_req.write;
        end
    end

    // contention on two cycles in a row hands the grant to the other side
    a_alternate: assert property (@(posedge clk) disable iff (!reset_n)
        ($past(host_valid && eng_valid) && host_valid && eng_valid)
            |-> (eng_ready != $past(eng_ready)));

    // a host turned away and still asking wins on the next cycle
    a_no_starve: assert property (@(posedge clk) disable iff (!reset_n)
        ($past(host_valid && !host_ready) && host_valid) |-> host_ready);

endmodule

`default_nettype wire

// File: ecc_fixed_msb.sv
/* fixed-MSB scalar blinding, registers scalar+q then scalar+2q
   and selects the sum whose bit REG_SIZE is set */

`default_nettype none

module ecc_fixed_msb #(
    parameter int                  REG_SIZE    = 384,
    parameter logic [REG_SIZE-1:0] GROUP_ORDER = {
        192'hffffffffffffffffffffffffffffffffffffffffffffffff,
        192'hc7634d81f4372ddf581a0db248b0a77aecec196accc52973
    }
) (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 en,
    input  wire  [REG_SIZE-1:0] data,
    output logic [REG_SIZE:0]   data_out
);

    // scalar+q with its carry in the top bit
    logic [REG_SIZE:0] sum_q;
    logic [REG_SIZE:0] sum_q_reg;
    // scalar+2q, only selected when scalar+q did not carry
    logic [REG_SIZE:0] sum_2q;
    logic [REG_SIZE:0] sum_2q_reg;

    // first stage, scalar + q
    ecc_adder #(
        .N(REG_SIZE)
    ) u_add_q (
        .a    (data),
        .b    (GROUP_ORDER),
        .cin  (1'b0),
        .s    (sum_q[REG_SIZE-1:0]),
        .cout (sum_q[REG_SIZE])
    );

    // second stage, adds q once more to the registered first sum
    // the dropped top bit is zero whenever this sum is the one selected
    ecc_adder #(
        .N(REG_SIZE)
    ) u_add_2q (
        .a    (sum_q_reg[REG_SIZE-1:0]),
        .b    (GROUP_ORDER),
        .cin  (1'b0),
        .s    (sum_2q[REG_SIZE-1:0]),
        .cout (sum_2q[REG_SIZE])
    );

    // two enabled cycles fill both stages from a stable input
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            sum_q_reg  <= '0;
            sum_2q_reg <= '0;
        end else if (en) begin
            sum_q_reg  <= sum_q;
            sum_2q_reg <= sum_2q;
        end
    end

    // carry out of scalar+q means that sum already has the MSB
    assign data_out = sum_q_reg[REG_SIZE] ? sum_q_reg : sum_2q_reg;

    // a scalar below q held for two enabled cycles yields a set top bit
    a_msb_set: assert property (@(posedge clk) disable iff (!reset_n)
        (en && (data < GROUP_ORDER)) ##1 (en && $stable(data)) |=> data_out[REG_SIZE]);

endmodule

`default_nettype wire

// File: ecc_adder.sv
/* N-bit ripple-carry adder with carry in and carry out */

`default_nettype none

module ecc_adder #(
    parameter int N = 32
) (
    input  wire  [N-1:0] a,
    input  wire  [N-1:0] b,
    input  wire          cin,
    output logic [N-1:0] s,
    output logic         cout
);

    // carry chain, carry[i] feeds bit i
    logic [N:0] carry;

    always_comb begin
        carry[0] = cin;
        for (int i = 0; i < N; i++) begin
            s[i]       = a[i] ^ b[i] ^ carry[i];
            // generate, or propagate the incoming carry
            carry[i+1] = (a[i] & b[i]) | (carry[i] & (a[i] ^ b[i]));
        end
    end

    assign cout = carry[N];

endmodule

`default_nettype wire

// File: ecc_cmd_pkg.sv
/* command and completion structs for the MSB-fix engine */

`default_nettype none

package ecc_cmd_pkg;

    // index of a scalar slot
    typedef logic [1:0] slot_t;

    // start command, scalar taken from src and result written to dst
    typedef struct packed {
        slot_t src;
        slot_t dst;
    } fix_cmd_t;

    // completion report
    // wide is set when scalar+q was kept, clear when scalar+2q was kept
    typedef struct packed {
        slot_t dst;
        logic  wide;
    } fix_done_t;

endpackage

`default_nettype wire

// File: ecc_mem_pkg.sv
/* memory bus definitions for the scalar store
   word width, slot geometry, address type, request and response structs */

`default_nettype none

package ecc_mem_pkg;

    // width of one bus word
    localparam int WORD_W = 32;

    // words per slot
    // room for a 384-bit result plus the word holding its top bit
    localparam int SLOT_WORDS = 16;

    // number of scalar slots in the store
    localparam int NUM_SLOTS = 4;

    // flat word address, slot index in the upper bits, word index below
    typedef logic [$clog2(NUM_SLOTS*SLOT_WORDS)-1:0] mem_addr_t;

    // request beat, one word per transfer
    typedef struct packed {
        logic              write;
        mem_addr_t         addr;
        logic [WORD_W-1:0] wdata;
    } mem_req_t;

    // read response, arrives one cycle after the read transfer
    typedef struct packed {
        logic [WORD_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire
